/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    localparam int imem_words = 256;
    localparam int imem_addr_w = 8;
    localparam int dmem_words = 64;
    localparam int dmem_addr_w = 6;

    // Major opcodes of the supported RV32I subset.
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_add  = 3'b000; // ADD, SUB and ADDI.
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_word = 3'b010; // LW and SW.
    localparam logic [2:0] f3_beq  = 3'b000;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

    // ADDI x0,x0,0.
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire

/* hw/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   prog_we,
    input  logic [imem_addr_w-1:0] prog_addr,
    input  logic [xlen-1:0]        prog_data,
    input  logic                   stall,
    input  logic                   branch_taken,
    input  logic [xlen-1:0]        branch_target,
    output logic                   if_valid,
    output logic [xlen-1:0]        if_pc,
    output logic [xlen-1:0]        if_instr
);

    logic [xlen-1:0]        imem [imem_words];
    logic [xlen-1:0]        pc;
    logic [imem_addr_w-1:0] pc_index;

    assign pc_index = pc[imem_addr_w+1:2]; // Word index into the array.

    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // A redirect wins over a stall and kills the slot being fetched.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (branch_taken) begin
            pc       <= branch_target;
            if_valid <= 1'b0;
        end else if (stall) begin
            pc <= pc; // Decode holds the same slot.
        end else if (run) begin
            pc       <= pc + xlen'(4);
            if_valid <= 1'b1;
        end else begin
            if_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (branch_taken) begin
            if_instr <= nop_instr;
        end else if (!stall) begin
            if_pc    <= pc;
            if_instr <= run ? imem[pc_index] : nop_instr;
        end
    end

endmodule

`default_nettype wire

/* hw/register_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module register_bank import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  write_enable,
    input  logic [reg_addr_w-1:0] write_address,
    input  logic [xlen-1:0]       write_value,
    input  logic [reg_addr_w-1:0] read_address1,
    input  logic [reg_addr_w-1:0] read_address2,
    output logic [xlen-1:0]       value1,
    output logic [xlen-1:0]       value2
);

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_address != '0)) begin
            regs[write_address] <= write_value;
        end
    end

    // The value written this cycle is visible to a read of the same register.
    assign value1 = (read_address1 == '0) ? '0 :
                    (write_enable && (write_address == read_address1)) ? write_value :
                    regs[read_address1];
    assign value2 = (read_address2 == '0) ? '0 :
                    (write_enable && (write_address == read_address2)) ? write_value :
                    regs[read_address2];

endmodule

`default_nettype wire

/* hw/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  if_valid,
    input  logic [xlen-1:0]       if_pc,
    input  logic [xlen-1:0]       if_instr,
    input  logic                  flush,
    output logic [reg_addr_w-1:0] rb_read_address1,
    output logic [reg_addr_w-1:0] rb_read_address2,
    input  logic [xlen-1:0]       rb_value1,
    input  logic [xlen-1:0]       rb_value2,
    output logic                  stall,
    output logic                  id_valid,
    output logic [xlen-1:0]       id_pc,
    output logic [reg_addr_w-1:0] id_rs1,
    output logic [reg_addr_w-1:0] id_rs2,
    output logic [reg_addr_w-1:0] id_rd,
    output logic [xlen-1:0]       id_val1,
    output logic [xlen-1:0]       id_val2,
    output logic [xlen-1:0]       id_imm,
    output alu_op_t               id_alu_op,
    output logic                  id_alu_src,
    output logic                  id_reg_write,
    output logic                  id_mem_read,
    output logic                  id_mem_write,
    output logic                  id_branch
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_s;
    logic [xlen-1:0]       imm_b;
    logic [xlen-1:0]       imm;
    logic                  known;
    logic                  uses_rs2;
    alu_op_t               alu_op;
    logic                  alu_src;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  branch;
    logic                  bubble;

    assign opcode = if_instr[6:0];
    assign rd     = if_instr[11:7];
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign funct7 = if_instr[31:25];

    assign imm_i = {{(xlen-12){if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{(xlen-12){if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{(xlen-13){if_instr[31]}}, if_instr[31], if_instr[7],
                    if_instr[30:25], if_instr[11:8], 1'b0};

    assign rb_read_address1 = rs1;
    assign rb_read_address2 = rs2;

    always_comb begin
        known     = 1'b1;
        uses_rs2  = 1'b0;
        alu_op    = alu_add;
        alu_src   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        imm       = imm_i;
        case (opcode)
            op_rtype: begin
                uses_rs2  = 1'b1;
                reg_write = 1'b1;
                if (funct7 == f7_sub) begin
                    alu_op = alu_sub;
                    known  = (funct3 == f3_add);
                end else begin
                    known = (funct7 == f7_base);
                    case (funct3)
                        f3_add:  alu_op = alu_add;
                        f3_slt:  alu_op = alu_slt;
                        f3_xor:  alu_op = alu_xor;
                        f3_or:   alu_op = alu_or;
                        f3_and:  alu_op = alu_and;
                        default: known = 1'b0;
                    endcase
                end
            end
            op_itype: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                known     = (funct3 == f3_add); // Only ADDI.
            end
            op_load: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
                known     = (funct3 == f3_word);
            end
            op_store: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                uses_rs2  = 1'b1;
                imm       = imm_s;
                known     = (funct3 == f3_word);
            end
            op_branch: begin
                alu_op   = alu_sub;
                branch   = 1'b1;
                uses_rs2 = 1'b1;
                imm      = imm_b;
                known    = (funct3 == f3_beq);
            end
            default: known = 1'b0;
        endcase
    end

    // The load now in execute has its data only after the memory stage.
    assign stall = if_valid && known && id_valid && id_mem_read && (id_rd != '0) &&
                   ((id_rd == rs1) || (uses_rs2 && (id_rd == rs2)));

    assign bubble = flush || stall || !if_valid || !known;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid     <= 1'b0;
            id_reg_write <= 1'b0;
            id_mem_read  <= 1'b0;
            id_mem_write <= 1'b0;
            id_branch    <= 1'b0;
        end else begin
            id_valid     <= !bubble;
            id_reg_write <= !bubble && reg_write;
            id_mem_read  <= !bubble && mem_read;
            id_mem_write <= !bubble && mem_write;
            id_branch    <= !bubble && branch;
        end
    end

    always_ff @(posedge clk) begin
        id_pc      <= if_pc;
        id_rs1     <= rs1;
        id_rs2     <= uses_rs2 ? rs2 : '0; // An immediate field never matches a forward.
        id_rd      <= rd;
        id_val1    <= rb_value1;
        id_val2    <= rb_value2;
        id_imm     <= imm;
        id_alu_op  <= alu_op;
        id_alu_src <= alu_src;
    end

    // A stalled instruction is offered again on the next cycle, and then it goes ahead.
    assert property (@(posedge clk) disable iff (rst)
        stall |=> (if_valid && $stable(if_instr) && !stall));

endmodule

`default_nettype wire

/* hw/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_valid,
    input  logic [xlen-1:0]       id_pc,
    input  logic [reg_addr_w-1:0] id_rs1,
    input  logic [reg_addr_w-1:0] id_rs2,
    input  logic [reg_addr_w-1:0] id_rd,
    input  logic [xlen-1:0]       id_val1,
    input  logic [xlen-1:0]       id_val2,
    input  logic [xlen-1:0]       id_imm,
    input  alu_op_t               id_alu_op,
    input  logic                  id_alu_src,
    input  logic                  id_reg_write,
    input  logic                  id_mem_read,
    input  logic                  id_mem_write,
    input  logic                  id_branch,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_value,
    input  logic                  wb_reg_write,
    output logic                  branch_taken,
    output logic [xlen-1:0]       branch_target,
    output logic                  ex_valid,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic [xlen-1:0]       ex_result,
    output logic [xlen-1:0]       ex_store_data,
    output logic                  ex_reg_write,
    output logic                  ex_mem_read,
    output logic                  ex_mem_write
);

    logic            fwd_ex1;
    logic            fwd_ex2;
    logic            fwd_wb1;
    logic            fwd_wb2;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;

    // The previous instruction's ALU result is newer than the writeback value.
    assign fwd_ex1 = ex_reg_write && !ex_mem_read && (ex_rd != '0) && (ex_rd == id_rs1);
    assign fwd_ex2 = ex_reg_write && !ex_mem_read && (ex_rd != '0) && (ex_rd == id_rs2);
    assign fwd_wb1 = wb_reg_write && (wb_rd == id_rs1);
    assign fwd_wb2 = wb_reg_write && (wb_rd == id_rs2);

    assign op1 = fwd_ex1 ? ex_result : fwd_wb1 ? wb_value : id_val1;
    assign op2 = fwd_ex2 ? ex_result : fwd_wb2 ? wb_value : id_val2;

    assign alu_b = id_alu_src ? id_imm : op2;

    always_comb begin
        case (id_alu_op)
            alu_add: alu_result = op1 + alu_b;
            alu_sub: alu_result = op1 - alu_b;
            alu_and: alu_result = op1 & alu_b;
            alu_or:  alu_result = op1 | alu_b;
            alu_xor: alu_result = op1 ^ alu_b;
            alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(op1) < $signed(alu_b)};
            default: alu_result = op1 + alu_b;
        endcase
    end

    assign branch_taken  = id_branch && (op1 == op2);
    assign branch_target = id_pc + id_imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end else begin
            ex_valid     <= id_valid;
            ex_reg_write <= id_reg_write;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd         <= id_rd;
        ex_result     <= alu_result;
        ex_store_data <= op2;
    end

    // Decode stalls a load's consumer, so its data never has to come from here.
    assert property (@(posedge clk) disable iff (rst)
        !(id_valid && ex_reg_write && ex_mem_read && (ex_rd != '0) &&
          ((ex_rd == id_rs1) || (ex_rd == id_rs2))));

    assert property (@(posedge clk) disable iff (rst)
        branch_taken |-> (branch_target[1:0] == 2'b00));

endmodule

`default_nettype wire

/* hw/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ex_valid,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic [xlen-1:0]       ex_result,
    input  logic [xlen-1:0]       ex_store_data,
    input  logic                  ex_reg_write,
    input  logic                  ex_mem_read,
    input  logic                  ex_mem_write,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_value,
    output logic                  wb_reg_write
);

    logic [xlen-1:0]        dmem [dmem_words];
    logic [dmem_addr_w-1:0] word_index;
    logic [xlen-1:0]        load_data;

    assign word_index = ex_result[dmem_addr_w+1:2];
    assign load_data  = dmem[word_index];

    // Unwritten words read as zero after reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dmem_words; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem_write) begin
            dmem[word_index] <= ex_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
        end else begin
            wb_valid     <= ex_valid;
            wb_reg_write <= ex_valid && ex_reg_write && (ex_rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= ex_rd;
        wb_value <= ex_mem_read ? load_data : ex_result;
    end

    assert property (@(posedge clk) disable iff (rst)
        (ex_mem_read || ex_mem_write) |-> (ex_result[1:0] == 2'b00));

endmodule

`default_nettype wire

/* hw/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   prog_we,
    input  logic [imem_addr_w-1:0] prog_addr,
    input  logic [xlen-1:0]        prog_data,
    output logic                   retire_valid,
    output logic [reg_addr_w-1:0]  retire_rd,
    output logic [xlen-1:0]        retire_value
);

    logic                  if_valid;
    logic [xlen-1:0]       if_pc;
    logic [xlen-1:0]       if_instr;
    logic                  stall;
    logic                  branch_taken;
    logic [xlen-1:0]       branch_target;

    logic [reg_addr_w-1:0] rb_read_address1;
    logic [reg_addr_w-1:0] rb_read_address2;
    logic [xlen-1:0]       rb_value1;
    logic [xlen-1:0]       rb_value2;

    logic                  id_valid;
    logic [xlen-1:0]       id_pc;
    logic [reg_addr_w-1:0] id_rs1;
    logic [reg_addr_w-1:0] id_rs2;
    logic [reg_addr_w-1:0] id_rd;
    logic [xlen-1:0]       id_val1;
    logic [xlen-1:0]       id_val2;
    logic [xlen-1:0]       id_imm;
    alu_op_t               id_alu_op;
    logic                  id_alu_src;
    logic                  id_reg_write;
    logic                  id_mem_read;
    logic                  id_mem_write;
    logic                  id_branch;

    logic                  ex_valid;
    logic [reg_addr_w-1:0] ex_rd;
    logic [xlen-1:0]       ex_result;
    logic [xlen-1:0]       ex_store_data;
    logic                  ex_reg_write;
    logic                  ex_mem_read;
    logic                  ex_mem_write;

    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_value;
    logic                  wb_reg_write;

    fetch fetch (.*);

    // A taken branch also squashes the instruction sitting in decode.
    decode decode (
        .flush(branch_taken),
        .*
    );

    register_bank register_bank (
        .clk(clk),
        .rst(rst),
        .write_enable(wb_reg_write),
        .write_address(wb_rd),
        .write_value(wb_value),
        .read_address1(rb_read_address1),
        .read_address2(rb_read_address2),
        .value1(rb_value1),
        .value2(rb_value2)
    );

    execute execute (.*);

    memory_stage memory_stage (.*);

    assign retire_valid = wb_valid && wb_reg_write;
    assign retire_rd    = wb_rd;
    assign retire_value = wb_value;

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam int half_period_ns = 2; // 4 ns period.

    initial clk = 1'b0;

    always #half_period_ns clk = ~clk;

endmodule

`default_nettype wire

/* verification/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int prog_len       = 200;
    localparam int halt_index     = prog_len - 1;
    localparam int reset_cycles   = 4;
    localparam int quiet_limit    = 20;
    localparam int timeout_cycles = imem_words + 3 * prog_len + 100;

    typedef enum logic [3:0] {
        ins_add, ins_sub, ins_and, ins_or, ins_xor, ins_slt,
        ins_addi, ins_lw, ins_sw, ins_beq
    } ins_t;

    logic                   clk;
    logic                   rst;
    logic                   run;
    logic                   prog_we;
    logic [imem_addr_w-1:0] prog_addr;
    logic [xlen-1:0]        prog_data;
    logic                   retire_valid;
    logic [reg_addr_w-1:0]  retire_rd;
    logic [xlen-1:0]        retire_value;

    ins_t        kinds [prog_len];
    logic [2:0]  rd_f [prog_len];
    logic [2:0]  rs1_f [prog_len];
    logic [2:0]  rs2_f [prog_len];
    logic [31:0] imm_f [prog_len];
    logic [31:0] program_words [imem_words];

    logic [4:0]  exp_rd [$];
    logic [31:0] exp_value [$];

    logic [15:0] lfsr_state;
    int          retired_count = 0;
    int          quiet_cycles = 0;
    int          cycle_count = 0;

    tb_clock clock_gen (.clk(clk));

    cpu uut (
        .clk(clk),
        .rst(rst),
        .run(run),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_value(retire_value)
    );

    // Taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s: expected 32'h%08h actual 32'h%08h", name, expected, actual);
        abort_run();
    endtask

    // Standard RV32I encodings.
    function automatic logic [31:0] encode(input int i);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        rd  = {2'b00, rd_f[i]};
        rs1 = {2'b00, rs1_f[i]};
        rs2 = {2'b00, rs2_f[i]};
        imm = imm_f[i];
        case (kinds[i])
            ins_add:  return {f7_base, rs2, rs1, f3_add, rd, op_rtype};
            ins_sub:  return {f7_sub, rs2, rs1, f3_add, rd, op_rtype};
            ins_and:  return {f7_base, rs2, rs1, f3_and, rd, op_rtype};
            ins_or:   return {f7_base, rs2, rs1, f3_or, rd, op_rtype};
            ins_xor:  return {f7_base, rs2, rs1, f3_xor, rd, op_rtype};
            ins_slt:  return {f7_base, rs2, rs1, f3_slt, rd, op_rtype};
            ins_addi: return {imm[11:0], rs1, f3_add, rd, op_itype};
            ins_lw:   return {imm[11:0], rs1, f3_word, rd, op_load};
            ins_sw:   return {imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store};
            default:  return {imm[12], imm[10:5], rs2, rs1, f3_beq, imm[4:1], imm[11], op_branch};
        endcase
    endfunction

    task automatic build_program();
        logic [3:0]  pick;
        logic [31:0] bits;
        int          k;
        for (int idx = 0; idx < halt_index; idx++) begin
            pick       = 4'(take_bits(4));
            rd_f[idx]  = 3'(take_bits(3));
            rs1_f[idx] = 3'(take_bits(3));
            rs2_f[idx] = 3'(take_bits(3));
            imm_f[idx] = '0;
            case (pick)
                4'd0, 4'd1: kinds[idx] = ins_add;
                4'd2:       kinds[idx] = ins_sub;
                4'd3:       kinds[idx] = ins_and;
                4'd4:       kinds[idx] = ins_or;
                4'd5:       kinds[idx] = ins_xor;
                4'd6:       kinds[idx] = ins_slt;
                4'd7, 4'd8, 4'd9: begin
                    kinds[idx] = ins_addi;
                    bits = take_bits(12);
                    imm_f[idx] = {{20{bits[11]}}, bits[11:0]};
                end
                4'd10, 4'd11: begin
                    kinds[idx] = ins_lw;
                    rs1_f[idx] = 3'd0; // Base is always x0.
                    imm_f[idx] = take_bits(6) << 2;
                end
                4'd12, 4'd13: begin
                    kinds[idx] = ins_sw;
                    rs1_f[idx] = 3'd0;
                    imm_f[idx] = take_bits(6) << 2;
                end
                default: begin
                    kinds[idx] = ins_beq;
                    k = int'(take_bits(2)) % 3 + 1;
                    if (idx + k > halt_index) begin
                        k = halt_index - idx; // Never jump past the halt loop.
                    end
                    imm_f[idx] = 32'(k) << 2;
                end
            endcase
        end
        kinds[halt_index] = ins_beq;
        rd_f[halt_index]  = 3'd0;
        rs1_f[halt_index] = 3'd0;
        rs2_f[halt_index] = 3'd0;
        imm_f[halt_index] = '0;
        for (int i = 0; i < imem_words; i++) begin
            program_words[i] = (i < prog_len) ? encode(i) : nop_instr;
        end
    endtask

    // Sequential execution of the program up to the halt loop.
    task automatic run_model();
        logic [31:0] regs [8];
        logic [31:0] mem [dmem_words];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] result;
        logic        writes;
        int          idx;
        int          next_idx;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            mem[i] = '0;
        end
        idx = 0;
        while (idx != halt_index) begin
            a        = regs[rs1_f[idx]];
            b        = regs[rs2_f[idx]];
            addr     = a + imm_f[idx];
            result   = '0;
            writes   = 1'b1;
            next_idx = idx + 1;
            case (kinds[idx])
                ins_add:  result = a + b;
                ins_sub:  result = a - b;
                ins_and:  result = a & b;
                ins_or:   result = a | b;
                ins_xor:  result = a ^ b;
                ins_slt:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                ins_addi: result = addr;
                ins_lw:   result = mem[addr[dmem_addr_w+1:2]];
                ins_sw: begin
                    mem[addr[dmem_addr_w+1:2]] = b;
                    writes = 1'b0;
                end
                default: begin
                    writes = 1'b0;
                    if (a == b) begin
                        next_idx = idx + int'(imm_f[idx] >> 2);
                    end
                end
            endcase
            if (writes && (rd_f[idx] != 3'd0)) begin
                regs[rd_f[idx]] = result;
                exp_rd.push_back({2'b00, rd_f[idx]});
                exp_value.push_back(result);
            end
            idx = next_idx;
        end
    endtask

    always @(negedge clk) begin
        if (!run) begin
            assert (!retire_valid)
                else report_problem("A retirement appeared while run was low.");
        end else if (retire_valid) begin
            quiet_cycles = 0;
            assert (retired_count < exp_rd.size())
                else report_problem("A retirement appeared after the last expected one.");
            if (retired_count < exp_rd.size()) begin
                assert (retire_rd == exp_rd[retired_count])
                    else report_mismatch($sformatf("retire %0d rd", retired_count),
                                         32'(exp_rd[retired_count]), 32'(retire_rd));
                assert (retire_value == exp_value[retired_count])
                    else report_mismatch($sformatf("retire %0d value", retired_count),
                                         exp_value[retired_count], retire_value);
                retired_count++;
            end
        end else if (retired_count == exp_rd.size()) begin
            quiet_cycles++;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle_count++;
            if (cycle_count > timeout_cycles) begin
                report_problem($sformatf("Timeout after %0d cycles with %0d of %0d retirements.",
                                         timeout_cycles, retired_count, exp_rd.size()));
            end
        end
    end

    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        lfsr_state = 16'd9;
        build_program();
        run_model();
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < imem_words; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= imem_addr_w'(i);
            prog_data <= program_words[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        run     <= 1'b1;
        while (!((retired_count == exp_rd.size()) && (quiet_cycles >= quiet_limit))) begin
            @(posedge clk);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/cpu_pkg.sv
hw/fetch.sv
hw/register_bank.sv
hw/decode.sv
hw/execute.sv
hw/memory_stage.sv
hw/cpu.sv
verification/tb_clock.sv
verification/cpu_tb.sv

/* Bender.yml */
package:
  name: rv32i_pipeline

sources:
  - hw/cpu_pkg.sv
  - hw/fetch.sv
  - hw/register_bank.sv
  - hw/decode.sv
  - hw/execute.sv
  - hw/memory_stage.sv
  - hw/cpu.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/cpu_tb.sv
